//--- rtl/risc5_pkg.sv
// ----------------------------------------
// risc5 core package
// widths, encodings and bundles shared by the core blocks
// ----------------------------------------
`default_nettype none

package risc5_pkg;

  // ----------------------------------------
  // basic types
  typedef logic [23:0] addr_t;  // bus and program address
  typedef logic [31:0] word_t;  // data word
  typedef logic [3:0]  reg_idx_t;  // register number

  localparam word_t INSTR_STEP = 32'd4;  // pc increment per instruction

  // ----------------------------------------
  // instruction encodings
  typedef enum logic [1:0] {
    FMT_REG    = 2'b00,  // register/register
    FMT_IMM    = 2'b01,  // register/immediate
    FMT_MEM    = 2'b10,  // load/store
    FMT_BRANCH = 2'b11  // stops the core
  } fmt_e;

  typedef enum logic [3:0] {
    FNC_MOV   = 4'h0,
    FNC_LSL   = 4'h1,
    FNC_ASR   = 4'h2,
    FNC_ROR   = 4'h3,
    FNC_AND   = 4'h4,
    FNC_ANN   = 4'h5,  // and-not
    FNC_IOR   = 4'h6,
    FNC_XOR   = 4'h7,
    FNC_ADD   = 4'h8,
    FNC_SUB   = 4'h9,
    FNC_RSV10 = 4'hA,  // codes 10..15 give zero
    FNC_RSV11 = 4'hB,
    FNC_RSV12 = 4'hC,
    FNC_RSV13 = 4'hD,
    FNC_RSV14 = 4'hE,
    FNC_RSV15 = 4'hF
  } alu_fnc_e;

  typedef struct packed {
    fmt_e        fmt;
    logic        u;  // load/store select in format 2
    logic        v;  // immediate extension bit
    reg_idx_t    ra;
    reg_idx_t    rb;
    reg_idx_t    rc;
    alu_fnc_e    fnc;
    logic [15:0] imm;
    logic [19:0] off;
  } instr_t;

  // ----------------------------------------
  // datapath controls
  typedef enum logic {A2_RC = 1'b0, A2_RA = 1'b1} a2_sel_e;
  typedef enum logic {OP1_PC = 1'b0, OP1_REG = 1'b1} op1_sel_e;
  typedef enum logic [1:0] {
    OP2_FOUR = 2'b00,
    OP2_REG  = 2'b01,
    OP2_IMM  = 2'b10,
    OP2_OFF  = 2'b11
  } op2_sel_e;

  typedef struct packed {
    logic     pc_load_reset;  // pc takes the reset vector
    logic     pc_we;
    logic     ir_we;
    a2_sel_e  a2_sel;
    logic     wb_from_bus;  // write back load data
    logic     reg_we;
    op1_sel_e op1_sel;
    op2_sel_e op2_sel;
    logic     force_add;
    logic     addr_from_alu;  // data access, not fetch
    logic     stb;
    logic     we;
  } ctrl_t;

  typedef struct packed {
    logic  stb;
    logic  we;
    addr_t addr;
    word_t dout;
  } bus_req_t;

endpackage

`default_nettype wire

//--- rtl/fetch_decode.sv
// ----------------------------------------
// fetch and decode
// program counter, instruction register and field split
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module fetch_decode #(
  parameter risc5_pkg::addr_t reset_pc = 24'hFFE000
) (
  input  logic                clk,
  input  logic                rst,
  input  risc5_pkg::ctrl_t    ctrl,
  input  risc5_pkg::word_t    res,
  input  risc5_pkg::word_t    bus_din,
  output risc5_pkg::addr_t    pc,
  output risc5_pkg::instr_t   instr
);

  import risc5_pkg::*;

  word_t ir;  // raw instruction word
  addr_t pc_next;

  // ----------------------------------------
  // program counter
  assign pc_next = ctrl.pc_load_reset ? reset_pc : res[23:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (ctrl.pc_we) begin
      pc <= pc_next;  // next instr or reset vector
    end
  end

  // ----------------------------------------
  // instruction register
  always_ff @(posedge clk) begin
    if (ctrl.ir_we) begin
      ir <= bus_din;  // loaded when fetch is acked
    end
  end

  // field split
  always_comb begin
    instr.fmt = fmt_e'(ir[31:30]);
    instr.u   = ir[29];
    instr.v   = ir[28];
    instr.ra  = ir[27:24];
    instr.rb  = ir[23:20];
    instr.rc  = ir[3:0];
    instr.fnc = alu_fnc_e'(ir[19:16]);
    instr.imm = ir[15:0];
    instr.off = ir[19:0];  // overlaps fnc and imm
  end

endmodule

`default_nettype wire

//--- rtl/core_ctrl.sv
// ----------------------------------------
// core controller
// fetch/execute FSM driving the datapath controls
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module core_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  risc5_pkg::instr_t instr,
  input  logic              bus_ack,
  output risc5_pkg::ctrl_t  ctrl
);

  import risc5_pkg::*;

  typedef enum logic [3:0] {
    RESET   = 4'd0,
    FETCH   = 4'd1,
    DECODE  = 4'd2,
    EXEC    = 4'd3,
    WB      = 4'd4,
    ADDR    = 4'd5,
    LOAD    = 4'd6,
    LOAD_WB = 4'd7,
    STORE   = 4'd8,
    HALT    = 4'd9
  } state_e;

  state_e state;
  state_e next_state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RESET;
    end else begin
      state <= next_state;
    end
  end

  // ----------------------------------------
  // next state and controls
  always_comb begin
    next_state = state;
    ctrl = '0;  // idle: no strobe, no writes
    case (state)
      RESET: begin
        next_state         = FETCH;
        ctrl.pc_load_reset = 1'b1;
        ctrl.pc_we         = 1'b1;
      end
      FETCH: begin
        if (bus_ack) begin
          next_state = DECODE;
        end
        ctrl.stb       = 1'b1;
        ctrl.op1_sel   = OP1_PC;
        ctrl.op2_sel   = OP2_FOUR;
        ctrl.force_add = 1'b1;  // pc + 4
        ctrl.pc_we     = bus_ack;
        ctrl.ir_we     = bus_ack;
      end
      DECODE: begin
        case (instr.fmt)
          FMT_REG, FMT_IMM: next_state = EXEC;
          FMT_MEM:          next_state = ADDR;
          default:          next_state = HALT;
        endcase
        ctrl.a2_sel = A2_RC;  // operand regs read here
      end
      EXEC: begin
        next_state   = WB;
        ctrl.a2_sel  = A2_RC;
        ctrl.op1_sel = OP1_REG;
        ctrl.op2_sel = (instr.fmt == FMT_REG) ? OP2_REG : OP2_IMM;
      end
      WB: begin
        next_state  = FETCH;
        ctrl.a2_sel = A2_RA;
        ctrl.reg_we = 1'b1;
      end
      ADDR: begin
        // u low means load
        next_state     = instr.u ? STORE : LOAD;
        ctrl.a2_sel    = A2_RA;  // store data from ra
        ctrl.op1_sel   = OP1_REG;
        ctrl.op2_sel   = OP2_OFF;
        ctrl.force_add = 1'b1;
      end
      LOAD: begin
        if (bus_ack) begin
          next_state = LOAD_WB;
        end
        ctrl.stb           = 1'b1;
        ctrl.addr_from_alu = 1'b1;
        ctrl.op1_sel       = OP1_REG;  // keep address steady
        ctrl.op2_sel       = OP2_OFF;
        ctrl.force_add     = 1'b1;
      end
      LOAD_WB: begin
        next_state       = FETCH;
        ctrl.a2_sel      = A2_RA;
        ctrl.wb_from_bus = 1'b1;
        ctrl.reg_we      = 1'b1;
      end
      STORE: begin
        if (bus_ack) begin
          next_state = FETCH;
        end
        ctrl.stb           = 1'b1;
        ctrl.we            = 1'b1;
        ctrl.addr_from_alu = 1'b1;
        ctrl.a2_sel        = A2_RA;  // hold store data
        ctrl.op1_sel       = OP1_REG;
        ctrl.op2_sel       = OP2_OFF;
        ctrl.force_add     = 1'b1;
      end
      HALT: begin
        next_state = HALT;  // format 3 stops here
      end
      default: begin
        next_state = RESET;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
// ----------------------------------------
// register file
// 16 x 32 with registered read ports, one write port
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  logic              clk,
  input  risc5_pkg::instr_t instr,
  input  risc5_pkg::ctrl_t  ctrl,
  input  risc5_pkg::word_t  alu_out,
  input  risc5_pkg::word_t  dr,
  output risc5_pkg::word_t  rd1,
  output risc5_pkg::word_t  rd2
);

  import risc5_pkg::*;

  word_t    regs [16];
  reg_idx_t a1;
  reg_idx_t a2;  // shared by read port 2 and write
  word_t    wd;

  assign a1 = instr.rb;
  assign a2 = (ctrl.a2_sel == A2_RA) ? instr.ra : instr.rc;
  assign wd = ctrl.wb_from_bus ? dr : alu_out;  // load data or alu

  always_ff @(posedge clk) begin
    rd1 <= regs[a1];
    rd2 <= regs[a2];
    if (ctrl.reg_we) begin
      regs[a2] <= wd;
    end
  end

endmodule

`default_nettype wire

//--- rtl/int_alu.sv
// ----------------------------------------
// integer ALU
// operand muxes, shifts, logic, add/sub, output register
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module int_alu (
  input  logic              clk,
  input  risc5_pkg::instr_t instr,
  input  risc5_pkg::ctrl_t  ctrl,
  input  risc5_pkg::addr_t  pc,
  input  risc5_pkg::word_t  rd1,
  input  risc5_pkg::word_t  rd2,
  output risc5_pkg::word_t  res,
  output risc5_pkg::word_t  alu_out
);

  import risc5_pkg::*;

  word_t       op1;
  word_t       op2;
  alu_fnc_e    fnc;
  logic [4:0]  sh;  // shift count
  logic [63:0] rot;

  // ----------------------------------------
  // operand selection
  assign op1 = (ctrl.op1_sel == OP1_PC) ? {8'h00, pc} : rd1;

  always_comb begin
    case (ctrl.op2_sel)
      OP2_FOUR: op2 = INSTR_STEP;
      OP2_REG:  op2 = rd2;
      OP2_IMM:  op2 = {{16{instr.v}}, instr.imm};  // v-extended
      default:  op2 = {{12{instr.off[19]}}, instr.off};
    endcase
  end

  assign fnc = ctrl.force_add ? FNC_ADD : instr.fnc;
  assign sh  = op2[4:0];
  assign rot = {op1, op1} >> sh;

  // ----------------------------------------
  // function select
  always_comb begin
    case (fnc)
      FNC_MOV: res = op2;
      FNC_LSL: res = op1 << sh;
      FNC_ASR: res = word_t'($signed(op1) >>> sh);
      FNC_ROR: res = rot[31:0];
      FNC_AND: res = op1 & op2;
      FNC_ANN: res = op1 & ~op2;
      FNC_IOR: res = op1 | op2;
      FNC_XOR: res = op1 ^ op2;
      FNC_ADD: res = op1 + op2;
      FNC_SUB: res = op1 - op2;
      default: res = '0;  // no mul/div/float
    endcase
  end

  always_ff @(posedge clk) begin
    alu_out <= res;
  end

endmodule

`default_nettype wire

//--- rtl/bus_port.sv
// ----------------------------------------
// bus port
// request assembly and load data register
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module bus_port (
  input  logic                clk,
  input  risc5_pkg::ctrl_t    ctrl,
  input  risc5_pkg::addr_t    pc,
  input  risc5_pkg::word_t    alu_out,
  input  risc5_pkg::word_t    rd2,
  input  risc5_pkg::word_t    bus_din,
  output risc5_pkg::bus_req_t bus_req,
  output risc5_pkg::word_t    dr
);

  import risc5_pkg::*;

  always_comb begin
    bus_req.stb  = ctrl.stb;
    bus_req.we   = ctrl.we;
    bus_req.addr = ctrl.addr_from_alu ? alu_out[23:0] : pc;  // data or fetch
    bus_req.dout = ctrl.we ? rd2 : '0;  // store data from ra, zero on reads
  end

  // sampled every edge, used after a load ack
  always_ff @(posedge clk) begin
    dr <= bus_din;
  end

endmodule

`default_nettype wire

//--- rtl/cpu_core.sv
// ----------------------------------------
// risc5 multicycle core, top level
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module cpu_core #(
  parameter risc5_pkg::addr_t reset_pc = 24'hFFE000
) (
  input  logic                clk,
  input  logic                rst,
  output risc5_pkg::bus_req_t bus_req,
  input  risc5_pkg::word_t    bus_din,
  input  logic                bus_ack
);

  import risc5_pkg::*;

  ctrl_t  ctrl;
  instr_t instr;
  addr_t  pc;
  word_t  res;  // combinational alu result
  word_t  alu_out;
  word_t  rd1;
  word_t  rd2;
  word_t  dr;

  // ----------------------------------------
  // input side
  fetch_decode #(
    .reset_pc(reset_pc)
  ) u_fetch_decode (
    .clk    (clk),
    .rst    (rst),
    .ctrl   (ctrl),
    .res    (res),
    .bus_din(bus_din),
    .pc     (pc),
    .instr  (instr)
  );

  // ----------------------------------------
  // processing part
  core_ctrl u_core_ctrl (
    .clk    (clk),
    .rst    (rst),
    .instr  (instr),
    .bus_ack(bus_ack),
    .ctrl   (ctrl)
  );

  reg_file u_reg_file (
    .clk    (clk),
    .instr  (instr),
    .ctrl   (ctrl),
    .alu_out(alu_out),
    .dr     (dr),
    .rd1    (rd1),
    .rd2    (rd2)
  );

  int_alu u_int_alu (
    .clk    (clk),
    .instr  (instr),
    .ctrl   (ctrl),
    .pc     (pc),
    .rd1    (rd1),
    .rd2    (rd2),
    .res    (res),
    .alu_out(alu_out)
  );

  // ----------------------------------------
  // output side
  bus_port u_bus_port (
    .clk    (clk),
    .ctrl   (ctrl),
    .pc     (pc),
    .alu_out(alu_out),
    .rd2    (rd2),
    .bus_din(bus_din),
    .bus_req(bus_req),
    .dr     (dr)
  );

endmodule

`default_nettype wire

//--- dv/tb_cpu_core.sv
// ----------------------------------------
// cpu_core testbench
// random program, wait-state memory and reference model
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_core;

  import risc5_pkg::*;

  localparam addr_t boot_pc = 24'hFFE000;
  localparam int    n_body  = 60;

  logic     clk;
  logic     rst;
  bus_req_t bus_req;
  word_t    bus_din;
  logic     bus_ack;

  integer   seed;
  int       n_errors;
  int       n_fetch;
  int       n_store;
  int       exp_fetch;
  int       exp_store;
  word_t    prog [$];
  word_t    bus_mem [int];  // word address index
  word_t    ref_mem [int];
  word_t    ref_regs [16];
  bus_req_t exp_q [$];  // expected requests in order
  bus_req_t cur_req;
  logic     busy;
  int       wait_left;

  cpu_core #(
    .reset_pc(boot_pc)
  ) u_dut (
    .clk    (clk),
    .rst    (rst),
    .bus_req(bus_req),
    .bus_din(bus_din),
    .bus_ack(bus_ack)
  );

  always #20 clk = ~clk;

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic word_t fill_word(input int wa);
    return {wa[21:0], wa[21:12]} ^ 32'h5ac3_96e1;  // unwritten memory
  endfunction

  function automatic word_t ref_alu(input logic [3:0] f, input word_t a, input word_t b);
    int s;
    s = b[4:0];
    case (f)
      FNC_MOV: return b;
      FNC_LSL: return a << s;
      FNC_ASR: return word_t'($signed(a) >>> s);
      FNC_ROR: return (a >> s) | (a << (32 - s));
      FNC_AND: return a & b;
      FNC_ANN: return a & ~b;
      FNC_IOR: return a | b;
      FNC_XOR: return a ^ b;
      FNC_ADD: return a + b;
      FNC_SUB: return a - b;
      default: return '0;
    endcase
  endfunction

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED %0t: %s %h, expected %h", $time, what, got, exp);
      n_errors++;
    end
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED %0t: %s %h, expected %h", $time, what, got, exp);
      n_errors++;
    end
  endtask

  // ----------------------------------------
  // program and reference model
  task automatic build_program();
    word_t w;
    int    k;
    for (int r = 0; r < 16; r++) begin
      w = $random(seed);
      w[31:29] = 3'b010;  // format 1 MOV, random v and imm
      w[27:24] = r[3:0];
      w[23:16] = 8'h00;
      if (r == 14) w = {2'b01, 2'b00, 4'd14, 8'h00, 16'h1000};  // data base
      prog.push_back(w);
    end
    for (int i = 0; i < n_body; i++) begin
      w = $random(seed);
      k = rand_below(10);
      w[27:24] = rand_below(14);  // r14 and r15 never written
      if (k < 7) begin
        w[31:29] = (k < 4) ? 3'b000 : 3'b010;
        w[19:16] = rand_below(10);
      end else begin
        w[31:28] = {2'b10, k > 7, 1'b0};  // u high means store
        w[23:20] = 4'd14;
        w[19:0]  = (rand_below(64) - 32) * 4;
        if (k > 7) w[27:24] = rand_below(16);
      end
      prog.push_back(w);
    end
    prog.push_back(32'hC000_0000);  // format 3
  endtask

  task automatic run_model();
    addr_t pc;
    word_t w;
    word_t a;
    word_t ea;
    int    wa;
    logic  halted;
    pc = boot_pc;
    halted = 1'b0;
    for (int n = 0; n < 1000 && !halted; n++) begin
      exp_q.push_back('{stb: 1'b1, we: 1'b0, addr: pc, dout: '0});
      exp_fetch++;
      wa = pc[23:2];
      w = ref_mem.exists(wa) ? ref_mem[wa] : fill_word(wa);
      pc = pc + 24'd4;
      a = ref_regs[w[23:20]];
      case (w[31:30])
        2'b00: ref_regs[w[27:24]] = ref_alu(w[19:16], a, ref_regs[w[3:0]]);
        2'b01: ref_regs[w[27:24]] = ref_alu(w[19:16], a, {{16{w[28]}}, w[15:0]});
        2'b10: begin
          ea = a + {{12{w[19]}}, w[19:0]};
          wa = ea[23:2];
          exp_q.push_back('{stb: 1'b1, we: w[29], addr: ea[23:0], dout: ref_regs[w[27:24]]});
          if (w[29]) begin
            ref_mem[wa] = ref_regs[w[27:24]];
            exp_store++;
          end else begin
            ref_regs[w[27:24]] = ref_mem.exists(wa) ? ref_mem[wa] : fill_word(wa);
          end
        end
        default: halted = 1'b1;
      endcase
    end
  endtask

  // ----------------------------------------
  // memory with random wait states
  task automatic serve_request(input bus_req_t req);
    bus_req_t exp;
    int       wa;
    wa = req.addr[23:2];
    if (exp_q.size() == 0) begin
      $display("bus request at %0t after the program should have halted", $time);
      n_errors++;
    end else begin
      exp = exp_q.pop_front();
      if (req.we !== exp.we) begin
        $display("FAILED %0t: write enable %b, expected %b", $time, req.we, exp.we);
        n_errors++;
      end
      check_addr(req.addr, exp.addr, "bus address");
      if (exp.we) check_word(req.dout, exp.dout, "store data");
    end
    if (req.we) begin
      bus_mem[wa] = req.dout;
      n_store++;
    end else begin
      bus_din <= bus_mem.exists(wa) ? bus_mem[wa] : fill_word(wa);
      if (req.addr >= boot_pc) n_fetch++;  // program sits above data
    end
  endtask

  always @(negedge clk) begin
    if (bus_ack) busy = 1'b0;  // transfer closed at last edge
    bus_ack <= 1'b0;
    if (busy && bus_req !== cur_req) begin
      $display("bus request changed before acknowledge at %0t", $time);
      n_errors++;
    end
    if (!busy && bus_req.stb) begin
      busy = 1'b1;
      cur_req = bus_req;
      wait_left = rand_below(4);
    end
    if (busy) begin
      if (wait_left == 0) begin
        serve_request(cur_req);
        bus_ack <= 1'b1;
      end else begin
        wait_left--;
      end
    end
  end

  initial begin
    int cycles;
    seed = 32'h8d65;
    clk = 1'b0;
    rst = 1'b1;
    bus_din = '0;
    bus_ack = 1'b0;
    busy = 1'b0;
    n_errors = 0;
    n_fetch = 0;
    n_store = 0;
    exp_fetch = 0;
    exp_store = 0;
    build_program();
    foreach (prog[i]) begin
      bus_mem[boot_pc[23:2] + i] = prog[i];
      ref_mem[boot_pc[23:2] + i] = prog[i];
    end
    run_model();
    repeat (16) @(negedge clk);
    rst = 1'b0;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 5000) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout with %0d bus requests still expected", exp_q.size());
      $display("Regression failed");
      $finish;
    end else begin
      for (int i = 0; i < 50; i++) begin
        @(negedge clk);
        if (bus_req.stb) begin
          $display("FAILED %0t: strobe raised in halt", $time);
          n_errors++;
        end
      end
      check_word(n_fetch, exp_fetch, "fetch count");
      check_word(n_store, exp_store, "store count");
      $display("errors %0d, fetches %0d, stores %0d", n_errors, n_fetch, n_store);
      if (n_errors == 0) begin
        $display("Regression passed");
      end else begin
        $display("Regression failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
rtl/risc5_pkg.sv
rtl/fetch_decode.sv
rtl/core_ctrl.sv
rtl/reg_file.sv
rtl/int_alu.sv
rtl/bus_port.sv
rtl/cpu_core.sv
dv/tb_cpu_core.sv

//--- Bender.yml
package:
  name: risc5_core

sources:
  - rtl/risc5_pkg.sv
  - rtl/fetch_decode.sv
  - rtl/core_ctrl.sv
  - rtl/reg_file.sv
  - rtl/int_alu.sv
  - rtl/bus_port.sv
  - rtl/cpu_core.sv
  - target: test
    files:
      - dv/tb_cpu_core.sv
